/* hdl/row_pkg.sv */
package row_pkg;

  // row geometry
  localparam int NUM_TILES = 4;

  // fifo depths, which also set the initial credits of each sender
  localparam int LINK_CREDITS = 2;
  localparam int HOST_CREDITS = 2;

  // response slots in the external receiver
  localparam int OUT_CREDITS = 4;

  // words in each tile memory
  localparam int MEM_WORDS = 16;

  // tile x coordinate
  typedef logic [1:0] x_cord_t;

  // word address inside one tile
  typedef logic [3:0] addr_t;

  // data word
  typedef logic [15:0] data_t;

  // credit counter, must hold OUT_CREDITS
  typedef logic [2:0] credit_cnt_t;

endpackage

/* hdl/row_link_if.sv */
`timescale 1ns/1ps

interface row_link_if;
  import row_pkg::*;

  // flit valid, one cycle per flit
  logic    v;
  x_cord_t dest_x;
  logic    store;
  addr_t   addr;
  data_t   data;
  // set on load responses
  logic    resp;
  // returned by the receiver, one pulse per freed slot
  logic    credit;

  modport snd (
    output v, dest_x, store, addr, data, resp,
    input  credit
  );

  modport rcv (
    input  v, dest_x, store, addr, data, resp,
    output credit
  );

endinterface

/* hdl/host_ingress.sv */
`timescale 1ns/1ps

module host_ingress (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             req_v_i,
  input  logic             req_store_i,
  input  row_pkg::x_cord_t req_x_i,
  input  row_pkg::addr_t   req_addr_i,
  input  row_pkg::data_t   req_data_i,
  output logic             req_credit_o,
  row_link_if.snd          link_o
);
  import row_pkg::*;

  // request storage, one slot per host credit
  x_cord_t x_q     [HOST_CREDITS];
  logic    store_q [HOST_CREDITS];
  addr_t   addr_q  [HOST_CREDITS];
  data_t   data_q  [HOST_CREDITS];

  logic [$clog2(HOST_CREDITS)-1:0]   wr_ptr;
  logic [$clog2(HOST_CREDITS)-1:0]   rd_ptr;
  logic [$clog2(HOST_CREDITS+1)-1:0] count;
  credit_cnt_t                       credits;
  logic                              push;
  logic                              pop;

  // host only sends while it holds credits, so no full check here
  assign push = req_v_i;
  assign pop  = (count != '0) && (credits != '0);

  assign link_o.v      = pop;
  assign link_o.dest_x = x_q[rd_ptr];
  assign link_o.store  = store_q[rd_ptr];
  assign link_o.addr   = addr_q[rd_ptr];
  assign link_o.data   = data_q[rd_ptr];
  assign link_o.resp   = 1'b0;

  // each pop frees a slot for the host
  assign req_credit_o = pop;

  always_ff @(posedge clk_i) begin
    if (push) begin
      x_q[wr_ptr]     <= req_x_i;
      store_q[wr_ptr] <= req_store_i;
      addr_q[wr_ptr]  <= req_addr_i;
      data_q[wr_ptr]  <= req_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= credit_cnt_t'(LINK_CREDITS);
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == HOST_CREDITS-1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == HOST_CREDITS-1) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // credits toward the first tile
      case ({pop, link_o.credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

/* hdl/mem_tile.sv */
`timescale 1ns/1ps

module mem_tile (
  input  logic             clk_i,
  input  logic             reset_i,
  input  row_pkg::x_cord_t tile_x_i,
  row_link_if.rcv          link_i,
  row_link_if.snd          link_o
);
  import row_pkg::*;

  // input fifo, one slot per link credit
  x_cord_t x_q     [LINK_CREDITS];
  logic    store_q [LINK_CREDITS];
  addr_t   addr_q  [LINK_CREDITS];
  data_t   data_q  [LINK_CREDITS];
  logic    resp_q  [LINK_CREDITS];

  logic [$clog2(LINK_CREDITS)-1:0]   wr_ptr;
  logic [$clog2(LINK_CREDITS)-1:0]   rd_ptr;
  logic [$clog2(LINK_CREDITS+1)-1:0] count;
  credit_cnt_t                       credits;

  // local word memory with a written flag per word
  data_t                mem [MEM_WORDS];
  logic [MEM_WORDS-1:0] written;

  x_cord_t head_x;
  logic    head_store;
  addr_t   head_addr;
  data_t   head_data;
  logic    head_resp;
  data_t   rd_data;
  logic    match;
  logic    pop;
  logic    send;

  assign head_x     = x_q[rd_ptr];
  assign head_store = store_q[rd_ptr];
  assign head_addr  = addr_q[rd_ptr];
  assign head_data  = data_q[rd_ptr];
  assign head_resp  = resp_q[rd_ptr];

  // responses from tiles further west never match here
  assign match = !head_resp && (head_x == tile_x_i);

  // unwritten words read as zero
  assign rd_data = written[head_addr] ? mem[head_addr] : '0;

  // every pop waits for a credit, even a local store
  assign pop  = (count != '0) && (credits != '0);
  assign send = pop && !(match && head_store);

  // a matched load leaves as a response in the same slot of the stream
  assign link_o.v      = send;
  assign link_o.dest_x = head_x;
  assign link_o.store  = head_store;
  assign link_o.addr   = head_addr;
  assign link_o.data   = match ? rd_data : head_data;
  assign link_o.resp   = head_resp || match;

  assign link_i.credit = pop;

  always_ff @(posedge clk_i) begin
    if (link_i.v) begin
      x_q[wr_ptr]     <= link_i.dest_x;
      store_q[wr_ptr] <= link_i.store;
      addr_q[wr_ptr]  <= link_i.addr;
      data_q[wr_ptr]  <= link_i.data;
      resp_q[wr_ptr]  <= link_i.resp;
    end
    if (pop && match && head_store) begin
      mem[head_addr] <= head_data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= credit_cnt_t'(LINK_CREDITS);
      written <= '0;
    end else begin
      if (link_i.v) begin
        wr_ptr <= (wr_ptr == LINK_CREDITS-1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LINK_CREDITS-1) ? '0 : rd_ptr + 1'b1;
      end
      if (pop && match && head_store) begin
        written[head_addr] <= 1'b1;
      end
      case ({link_i.v, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // credits toward the next hop east
      case ({send, link_o.credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

/* hdl/resp_egress.sv */
`timescale 1ns/1ps

module resp_egress (
  input  logic             clk_i,
  input  logic             reset_i,
  row_link_if.rcv          link_i,
  input  logic             resp_credit_i,
  output logic             resp_v_o,
  output row_pkg::x_cord_t resp_x_o,
  output row_pkg::addr_t   resp_addr_o,
  output row_pkg::data_t   resp_data_o
);
  import row_pkg::*;

  // fifo on the last link, store flag is not needed here
  x_cord_t x_q    [LINK_CREDITS];
  addr_t   addr_q [LINK_CREDITS];
  data_t   data_q [LINK_CREDITS];
  logic    resp_q [LINK_CREDITS];

  logic [$clog2(LINK_CREDITS)-1:0]   wr_ptr;
  logic [$clog2(LINK_CREDITS)-1:0]   rd_ptr;
  logic [$clog2(LINK_CREDITS+1)-1:0] count;
  credit_cnt_t                       out_credits;
  logic                              not_empty;
  logic                              drop;
  logic                              pop;

  assign not_empty = (count != '0);

  // a request that reached the end matched no tile
  assign drop = not_empty && !resp_q[rd_ptr];

  assign resp_v_o    = not_empty && resp_q[rd_ptr] && (out_credits != '0);
  assign resp_x_o    = x_q[rd_ptr];
  assign resp_addr_o = addr_q[rd_ptr];
  assign resp_data_o = data_q[rd_ptr];

  assign pop           = resp_v_o || drop;
  assign link_i.credit = pop;

  always_ff @(posedge clk_i) begin
    if (link_i.v) begin
      x_q[wr_ptr]    <= link_i.dest_x;
      addr_q[wr_ptr] <= link_i.addr;
      data_q[wr_ptr] <= link_i.data;
      resp_q[wr_ptr] <= link_i.resp;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      out_credits <= credit_cnt_t'(OUT_CREDITS);
    end else begin
      if (link_i.v) begin
        wr_ptr <= (wr_ptr == LINK_CREDITS-1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LINK_CREDITS-1) ? '0 : rd_ptr + 1'b1;
      end
      case ({link_i.v, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // slots left in the external receiver
      case ({resp_v_o, resp_credit_i})
        2'b10:   out_credits <= out_credits - 1'b1;
        2'b01:   out_credits <= out_credits + 1'b1;
        default: out_credits <= out_credits;
      endcase
    end
  end

endmodule

/* hdl/tile_row.sv */
`timescale 1ns/1ps

module tile_row (
  input  logic             clk_i,
  input  logic             reset_i,

  input  logic             req_v_i,
  input  row_pkg::x_cord_t req_x_i,
  input  logic             req_store_i,
  input  row_pkg::addr_t   req_addr_i,
  input  row_pkg::data_t   req_data_i,
  output logic             req_credit_o,

  output logic             resp_v_o,
  output row_pkg::x_cord_t resp_x_o,
  output row_pkg::addr_t   resp_addr_o,
  output row_pkg::data_t   resp_data_o,
  input  logic             resp_credit_i
);
  import row_pkg::*;

  // link[0] leaves ingress, link[NUM_TILES] enters egress
  row_link_if link [NUM_TILES+1] ();

  host_ingress ingress (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_v_i     (req_v_i),
    .req_store_i (req_store_i),
    .req_x_i     (req_x_i),
    .req_addr_i  (req_addr_i),
    .req_data_i  (req_data_i),
    .req_credit_o(req_credit_o),
    .link_o      (link[0])
  );

  for (genvar i = 0; i < NUM_TILES; i++) begin : tile
    mem_tile mt (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .tile_x_i(x_cord_t'(i)),
      .link_i  (link[i]),
      .link_o  (link[i+1])
    );
  end

  resp_egress egress (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .link_i       (link[NUM_TILES]),
    .resp_credit_i(resp_credit_i),
    .resp_v_o     (resp_v_o),
    .resp_x_o     (resp_x_o),
    .resp_addr_o  (resp_addr_o),
    .resp_data_o  (resp_data_o)
  );

endmodule

/* testbench/tile_row_checker.sv */
`timescale 1ns/1ps

module tile_row_checker (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             resp_v_i,
  input  row_pkg::x_cord_t resp_x_i,
  input  row_pkg::addr_t   resp_addr_i,
  input  row_pkg::data_t   resp_data_i,
  input  logic             exp_push_i,
  input  row_pkg::x_cord_t exp_x_i,
  input  row_pkg::addr_t   exp_addr_i,
  input  row_pkg::data_t   exp_data_i,
  input  logic             hold_i,
  input  logic             test_end_i,
  input  int               test_id_i,
  output int               pending_o,
  output int               checks_o,
  output int               errors_o
);
  import row_pkg::*;

  // loads in issue order, responses must come back the same way
  x_cord_t x_q    [$];
  addr_t   addr_q [$];
  data_t   data_q [$];
  int      test_checks = 0;
  int      test_errors = 0;
  int      held_seen   = 0;

  initial begin
    pending_o = 0;
    checks_o  = 0;
    errors_o  = 0;
  end

  task automatic compare(input string name, input data_t expected, input data_t actual);
    begin
      if (expected !== actual) begin
        $display("CHECK FAILED time %0t signal %s expected %h actual %h",
                 $time, name, expected, actual);
        errors_o++;
        test_errors++;
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (exp_push_i) begin
        x_q.push_back(exp_x_i);
        addr_q.push_back(exp_addr_i);
        data_q.push_back(exp_data_i);
      end
      if (resp_v_i) begin
        if (data_q.size() == 0) begin
          $display("unexpected response at time %0t with no load outstanding", $time);
          errors_o++;
          test_errors++;
        end else begin
          compare("resp_x_o", data_t'(x_q.pop_front()), data_t'(resp_x_i));
          compare("resp_addr_o", data_t'(addr_q.pop_front()), data_t'(resp_addr_i));
          compare("resp_data_o", data_q.pop_front(), resp_data_i);
          checks_o++;
          test_checks++;
        end
        // receiver is full after OUT_CREDITS responses
        if (hold_i) begin
          held_seen++;
          if (held_seen > OUT_CREDITS) begin
            $display("response %0d arrived at time %0t with no external credit left",
                     held_seen, $time);
            errors_o++;
            test_errors++;
          end
        end
      end
      if (test_end_i) begin
        if (data_q.size() != 0) begin
          $display("test %0d: %0d expected responses never arrived", test_id_i, data_q.size());
          errors_o++;
          test_errors++;
          x_q.delete();
          addr_q.delete();
          data_q.delete();
        end
        $display("test %0d finished: %0d responses checked, %0d errors",
                 test_id_i, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
      end
    end
    pending_o <= data_q.size();
  end

endmodule

/* testbench/tile_row_props.sv */
`timescale 1ns/1ps

module tile_row_props #(
  parameter int CREDITS = 2,
  parameter int DEPTH   = 2
) (
  input logic                       clk_i,
  input logic                       reset_i,
  input logic                       v_i,
  input logic                       credit_i,
  input logic                       push_i,
  input logic [$clog2(DEPTH+1)-1:0] count_i,
  input logic [1:0]                 ctl_i
);

  // credits held by the sender as seen on its valid and credit lines
  int held;

  always @(posedge clk_i) begin
    if (reset_i) begin
      held <= CREDITS;
    end else begin
      held <= held - (v_i ? 1 : 0) + (credit_i ? 1 : 0);
    end
  end

  // a sender never spends a credit it does not hold
  credit_safe: assert property (@(posedge clk_i) disable iff (reset_i)
    v_i |-> (held > 0))
    else $error("valid asserted with zero credits");

  // the receiver never frees more slots than it has
  credit_bound: assert property (@(posedge clk_i) disable iff (reset_i)
    held <= CREDITS)
    else $error("more credits returned than slots exist");

  fifo_safe: assert property (@(posedge clk_i) disable iff (reset_i)
    push_i |-> (count_i < DEPTH))
    else $error("fifo pushed while full");

  // valid and credit lines quiet on the first cycle out of reset
  reset_quiet: assert property (@(posedge clk_i)
    $fell(reset_i) |-> (ctl_i == '0))
    else $error("control outputs active right after reset");

endmodule

bind mem_tile tile_row_props #(
  .CREDITS(row_pkg::LINK_CREDITS),
  .DEPTH  (row_pkg::LINK_CREDITS)
) tile_props (
  .clk_i   (clk_i),
  .reset_i (reset_i),
  .v_i     (send),
  .credit_i(link_o.credit),
  .push_i  (link_i.v),
  .count_i (count),
  .ctl_i   ({send, pop})
);

// output credits and the ingress fifo
bind tile_row tile_row_props #(
  .CREDITS(row_pkg::OUT_CREDITS),
  .DEPTH  (row_pkg::HOST_CREDITS)
) row_props (
  .clk_i   (clk_i),
  .reset_i (reset_i),
  .v_i     (resp_v_o),
  .credit_i(resp_credit_i),
  .push_i  (req_v_i),
  .count_i (ingress.count),
  .ctl_i   ({resp_v_o, req_credit_o})
);

// first link out of ingress and the egress fifo
bind tile_row tile_row_props #(
  .CREDITS(row_pkg::LINK_CREDITS),
  .DEPTH  (row_pkg::LINK_CREDITS)
) link_props (
  .clk_i   (clk_i),
  .reset_i (reset_i),
  .v_i     (ingress.pop),
  .credit_i(tile[0].mt.pop),
  .push_i  (tile[row_pkg::NUM_TILES-1].mt.send),
  .count_i (egress.count),
  .ctl_i   ({ingress.pop, egress.pop})
);

/* testbench/tb_tile_row.sv */
`timescale 1ns/1ps

module tb_tile_row;
  import row_pkg::*;

  typedef struct packed {
    logic [3:0] test;
    x_cord_t    x;
    logic       store;
    addr_t      addr;
    data_t      data;
    data_t      exp;
  } req_t;

  logic    clk;
  logic    reset;
  logic    req_v;
  x_cord_t req_x;
  logic    req_store;
  addr_t   req_addr;
  data_t   req_data;
  logic    req_credit;
  logic    resp_v;
  x_cord_t resp_x;
  addr_t   resp_addr;
  data_t   resp_data;
  logic    resp_credit;

  // expectations and test markers toward the checker
  logic    exp_push;
  x_cord_t exp_x;
  addr_t   exp_addr;
  data_t   exp_data;
  logic    test_end;
  int      test_id;
  logic    credit_hold;
  int      pending;
  int      checks;
  int      chk_errors;

  req_t  table_q [$];
  data_t model_mem [NUM_TILES][MEM_WORDS];
  int    host_credits;
  int    owed;
  int    gap;
  int    cycles;
  int    timeout_limit;
  int    tb_errors;

  tile_row UUT (
    .clk_i        (clk),
    .reset_i      (reset),
    .req_v_i      (req_v),
    .req_x_i      (req_x),
    .req_store_i  (req_store),
    .req_addr_i   (req_addr),
    .req_data_i   (req_data),
    .req_credit_o (req_credit),
    .resp_v_o     (resp_v),
    .resp_x_o     (resp_x),
    .resp_addr_o  (resp_addr),
    .resp_data_o  (resp_data),
    .resp_credit_i(resp_credit)
  );

  tile_row_checker resp_chk (
    .clk_i      (clk),
    .reset_i    (reset),
    .resp_v_i   (resp_v),
    .resp_x_i   (resp_x),
    .resp_addr_i(resp_addr),
    .resp_data_i(resp_data),
    .exp_push_i (exp_push),
    .exp_x_i    (exp_x),
    .exp_addr_i (exp_addr),
    .exp_data_i (exp_data),
    .hold_i     (credit_hold),
    .test_end_i (test_end),
    .test_id_i  (test_id),
    .pending_o  (pending),
    .checks_o   (checks),
    .errors_o   (chk_errors)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // host side credits, the request sampled at this edge is spent here
  always @(posedge clk) begin
    if (reset) begin
      host_credits <= HOST_CREDITS;
    end else begin
      host_credits <= host_credits - (req_v ? 1 : 0) + (req_credit ? 1 : 0);
    end
  end

  // external receiver frees each slot after a random gap
  always @(posedge clk) begin
    int next_owed;
    next_owed = owed + (resp_v ? 1 : 0);
    if (reset) begin
      owed        <= 0;
      gap         <= 0;
      resp_credit <= 1'b0;
    end else if (!credit_hold && next_owed > 0 && gap == 0) begin
      resp_credit <= 1'b1;
      owed        <= next_owed - 1;
      gap         <= $urandom_range(3, 0);
    end else begin
      resp_credit <= 1'b0;
      owed        <= next_owed;
      if (gap > 0) begin
        gap <= gap - 1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_limit) begin
      $display("timeout: run did not finish within %0d cycles", timeout_limit);
      $display("Test failed");
      $finish;
    end
  end

  // expected load data follows the store history of each tile
  task automatic add_req(input int test, input int x, input logic store, input int addr,
                         input data_t data);
    req_t r;
    begin
      r.test  = test[3:0];
      r.x     = x_cord_t'(x);
      r.store = store;
      r.addr  = addr_t'(addr);
      r.data  = data;
      if (store) begin
        model_mem[x][addr] = data;
      end
      r.exp = model_mem[x][addr];
      table_q.push_back(r);
    end
  endtask

  task automatic build_table();
    begin
      for (int x = 0; x < NUM_TILES; x++) begin
        for (int a = 0; a < MEM_WORDS; a++) begin
          model_mem[x][a] = '0;
          add_req(1, x, 1'b0, a, '0);
        end
      end
      for (int x = 0; x < NUM_TILES; x++) begin
        add_req(2, x, 1'b1, 3*x+1, data_t'($urandom));
        add_req(2, x, 1'b0, 3*x+1, '0);
        add_req(2, x, 1'b1, 3*x+2, data_t'($urandom));
        add_req(2, x, 1'b0, 3*x+2, '0);
      end
      // same word in every tile, distinct values
      for (int x = 0; x < NUM_TILES; x++) begin
        add_req(3, x, 1'b1, 10, 16'ha0a0 ^ data_t'(x));
      end
      for (int x = 0; x < NUM_TILES; x++) begin
        add_req(3, x, 1'b0, 10, '0);
      end
      for (int i = 0; i < 6; i++) begin
        add_req(4, i % NUM_TILES, 1'b0, 3*(i % NUM_TILES)+2, '0);
      end
      for (int i = 0; i < 8; i++) begin
        add_req(5, 3 - (i % 4), 1'b0, (i < 4) ? 10 : 3*(3 - (i % 4))+1, '0);
      end
    end
  endtask

  task automatic send_req(input req_t r);
    begin
      @(posedge clk);
      while (host_credits - (req_v ? 1 : 0) <= 0) begin
        req_v    <= 1'b0;
        exp_push <= 1'b0;
        @(posedge clk);
      end
      req_v     <= 1'b1;
      req_x     <= r.x;
      req_store <= r.store;
      req_addr  <= r.addr;
      req_data  <= r.data;
      exp_push  <= !r.store;
      exp_x     <= r.x;
      exp_addr  <= r.addr;
      exp_data  <= r.exp;
    end
  endtask

  task automatic wait_pending(input int target, input int limit, output bit ok);
    int n;
    begin
      n = 0;
      @(posedge clk);
      while (pending > target && n < limit) begin
        @(posedge clk);
        n++;
      end
      ok = (pending <= target);
    end
  endtask

  task automatic run_test(input int t);
    int  n;
    bit  ok;
    begin
      n = 0;
      if (t == 4) begin
        // start with every external slot free
        @(posedge clk);
        while (owed != 0 || resp_credit) begin
          @(posedge clk);
        end
        credit_hold <= 1'b1;
      end
      foreach (table_q[i]) begin
        if (table_q[i].test == t) begin
          send_req(table_q[i]);
          n++;
        end
      end
      @(posedge clk);
      req_v    <= 1'b0;
      exp_push <= 1'b0;
      if (t == 4) begin
        wait_pending(n - OUT_CREDITS, n * (NUM_TILES+2) * 8, ok);
        if (!ok) begin
          $display("test 4: fewer than %0d responses arrived while credits were held",
                   OUT_CREDITS);
          tb_errors++;
        end
        // receiver is full, nothing else may come out
        repeat (40) @(posedge clk);
        credit_hold <= 1'b0;
      end
      wait_pending(0, n * (NUM_TILES+2) * 8, ok);
      test_end <= 1'b1;
      test_id  <= t;
      @(posedge clk);
      test_end <= 1'b0;
    end
  endtask

  initial begin
    reset       = 1'b1;
    req_v       = 1'b0;
    req_x       = '0;
    req_store   = 1'b0;
    req_addr    = '0;
    req_data    = '0;
    resp_credit = 1'b0;
    exp_push    = 1'b0;
    exp_x       = '0;
    exp_addr    = '0;
    exp_data    = '0;
    test_end    = 1'b0;
    test_id     = 0;
    credit_hold = 1'b0;
    owed        = 0;
    gap         = 0;
    cycles      = 0;
    tb_errors   = 0;
    void'($urandom(32'hf3d7b5c2));
    build_table();
    timeout_limit = table_q.size() * (NUM_TILES+2) * 8 + 200;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    for (int t = 1; t <= 5; t++) begin
      run_test(t);
    end
    @(posedge clk);
    $display("tests: 5, responses checked: %0d, errors: %0d", checks, chk_errors + tb_errors);
    if (chk_errors + tb_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
hdl/row_pkg.sv
hdl/row_link_if.sv
hdl/host_ingress.sv
hdl/mem_tile.sv
hdl/resp_egress.sv
hdl/tile_row.sv
testbench/tile_row_checker.sv
testbench/tile_row_props.sv
testbench/tb_tile_row.sv

/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_tile_row \
	  -f vlog.f -o sim_tile_row

run: compile
	@out="$$(./obj_dir/sim_tile_row)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
